// File: flist.f
+incdir+include
hw/cu_pkg.sv
hw/opcode_decode.sv
hw/cycle_sequencer.sv
hw/control_outputs.sv
hw/control_unit.sv
tests/tb_control_unit.sv

// File: hw/control_outputs.sv
`timescale 1ns/1ps
`default_nettype none

module control_outputs (
	input  wire cu_pkg::state_e   state,
	input  wire cu_pkg::decoded_t dec,
	output cu_pkg::ctrl_word_t    ctrl
);

	logic load_state;

	// Cycles in which the operand reaches its register
	assign load_state = state inside {cu_pkg::ST_IM0, cu_pkg::ST_ZP1,
		cu_pkg::ST_ABS2, cu_pkg::ST_PULL};

	always_comb begin
		ctrl                = '0;
		ctrl.sp_op          = cu_pkg::SP_HOLD;
		ctrl.write_select   = cu_pkg::WS_ZERO;
		ctrl.address_select = cu_pkg::AS_PC;
		ctrl.alu_select     = dec.alu_sel_ex;
		ctrl.alu_opcode     = cu_pkg::OP_PASS;
		ctrl.state          = state;

		case (state)
			cu_pkg::ST_FETCH: begin
				ctrl.instruction_load = 1'b1;
				ctrl.increment_pc     = 1'b1;
			end
			cu_pkg::ST_IM0: begin
				ctrl.increment_pc = 1'b1; // Skip the immediate byte
				ctrl.alu_opcode   = dec.alu_op_ex;
			end
			cu_pkg::ST_ZP0, cu_pkg::ST_ABS0: begin
				ctrl.increment_pc = 1'b1;
				ctrl.dirl_load    = 1'b1;
				ctrl.alu_select   = dec.alu_sel_ad;
				ctrl.alu_opcode   = cu_pkg::OP_ADR0;
			end
			cu_pkg::ST_ZP1: begin
				ctrl.address_select = cu_pkg::AS_ZERO;
				ctrl.alu_opcode     = dec.alu_op_ex;
			end
			cu_pkg::ST_ABS1: begin
				ctrl.increment_pc = 1'b1;
				ctrl.dirh_load    = 1'b1;
				ctrl.alu_select   = cu_pkg::AL_Z; // Carry only into high byte
				ctrl.alu_opcode   = cu_pkg::OP_ADR1;
			end
			cu_pkg::ST_ABS2: begin
				ctrl.address_select = cu_pkg::AS_ABS;
				ctrl.alu_opcode     = dec.alu_op_ex;
			end
			cu_pkg::ST_ZP_STORE: begin
				ctrl.read_write     = 1'b1;
				ctrl.write_select   = cu_pkg::WS_ALU;
				ctrl.address_select = cu_pkg::AS_ZERO;
			end
			cu_pkg::ST_ABS_STORE: begin
				ctrl.read_write     = 1'b1;
				ctrl.write_select   = cu_pkg::WS_ALU;
				ctrl.address_select = cu_pkg::AS_ABS;
			end
			cu_pkg::ST_ZP_WRITE: begin
				ctrl.read_write     = 1'b1;
				ctrl.write_select   = cu_pkg::WS_RESULT; // Modified value back
				ctrl.address_select = cu_pkg::AS_ZERO;
			end
			cu_pkg::ST_ABS_WRITE: begin
				ctrl.read_write     = 1'b1;
				ctrl.write_select   = cu_pkg::WS_RESULT;
				ctrl.address_select = cu_pkg::AS_ABS;
			end
			cu_pkg::ST_ABS_JMP:   ctrl.jmp_load = 1'b1;
			cu_pkg::ST_BRANCH_CHECK: begin
				ctrl.increment_pc = 1'b1; // Past the offset byte
				ctrl.alu_opcode   = dec.alu_op_ex;
			end
			cu_pkg::ST_BRANCH_GO: ctrl.branch_load = 1'b1;
			cu_pkg::ST_PUSH: begin
				ctrl.sp_op          = cu_pkg::SP_DEC;
				ctrl.read_write     = 1'b1;
				ctrl.write_select   = cu_pkg::WS_ALU;
				ctrl.address_select = cu_pkg::AS_STACK;
			end
			cu_pkg::ST_PULL: begin
				ctrl.sp_op          = cu_pkg::SP_INC;
				ctrl.address_select = cu_pkg::AS_STACK;
			end
			cu_pkg::ST_RST0: ctrl.rst_load = 1'b1;
			cu_pkg::ST_RST1: begin
				ctrl.pcl_load       = 1'b1;
				ctrl.address_select = cu_pkg::AS_RVL;
			end
			cu_pkg::ST_RST2: begin
				ctrl.pch_load       = 1'b1;
				ctrl.address_select = cu_pkg::AS_RVH;
			end
			default: ;
		endcase

		ctrl.a_load  = load_state && (dec.target == cu_pkg::A_REG);
		ctrl.x_load  = load_state && (dec.target == cu_pkg::X_REG);
		ctrl.y_load  = load_state && (dec.target == cu_pkg::Y_REG);
		ctrl.sp_load = load_state && (dec.target == cu_pkg::SP_REG);
	end

	// Writes only go to data memory or the stack page
	always_comb begin
		a_write_addr: assert (!ctrl.read_write || ctrl.address_select inside
			{cu_pkg::AS_ZERO, cu_pkg::AS_ABS, cu_pkg::AS_STACK})
			else $error("control_outputs: write with address select %0d",
				ctrl.address_select);
	end

endmodule

`default_nettype wire

// File: hw/control_unit.sv
`timescale 1ns/1ps
`default_nettype none

module control_unit (
	input  wire logic          clk,
	input  wire logic          rst,
	input  wire logic [7:0]    opcode,
	input  wire logic          branch_valid,
	output cu_pkg::ctrl_word_t ctrl
);

	cu_pkg::state_e      state;
	cu_pkg::inst_class_e fetch_class;
	cu_pkg::decoded_t    dec;

	opcode_decode u_opcode_decode (
		.clk         (clk),
		.rst         (rst),
		.opcode      (opcode),
		.state       (state),
		.fetch_class (fetch_class),
		.dec         (dec)
	);

	cycle_sequencer u_cycle_sequencer (
		.clk          (clk),
		.rst          (rst),
		.fetch_class  (fetch_class),
		.dec          (dec),
		.branch_valid (branch_valid),
		.state        (state)
	);

	control_outputs u_control_outputs (
		.state (state),
		.dec   (dec),
		.ctrl  (ctrl)
	);

endmodule

`default_nettype wire

// File: hw/cu_pkg.sv
`default_nettype none

package cu_pkg;

	// Cycle states of the instruction FSM
	typedef enum logic [5:0] {
		ST_FETCH        = 6'd0,
		ST_IM0          = 6'd1,
		ST_ZP0          = 6'd2,
		ST_ZP1          = 6'd3,
		ST_ABS0         = 6'd4,
		ST_ABS1         = 6'd5,
		ST_ABS2         = 6'd6,
		ST_ZP_WRITE     = 6'd14,
		ST_ABS_WRITE    = 6'd15,
		ST_ZP_STORE     = 6'd16,
		ST_ABS_STORE    = 6'd17,
		ST_BRANCH_CHECK = 6'd19,
		ST_BRANCH_GO    = 6'd20,
		ST_PUSH         = 6'd21,
		ST_PULL         = 6'd22,
		ST_ABS_JMP      = 6'd23,
		ST_RST0         = 6'd41,
		ST_RST1         = 6'd42,
		ST_RST2         = 6'd43
	} state_e;

	typedef enum logic [3:0] {
		AS_PC    = 4'd0,
		AS_ZERO  = 4'd1,
		AS_ABS   = 4'd2,
		AS_STACK = 4'd7,
		AS_RVL   = 4'd10, // Reset vector low byte
		AS_RVH   = 4'd11  // Reset vector high byte
	} addr_sel_e;

	typedef enum logic [2:0] {
		AL_A  = 3'd0,
		AL_F  = 3'd1,
		AL_M  = 3'd2,
		AL_SP = 3'd3,
		AL_X  = 3'd4,
		AL_Y  = 3'd5,
		AL_Z  = 3'd6
	} alu_sel_e;

	typedef enum logic [2:0] {
		WS_ALU    = 3'd0,
		WS_RESULT = 3'd1,
		WS_ZERO   = 3'd5
	} write_sel_e;

	typedef enum logic [1:0] {
		SP_HOLD = 2'd0,
		SP_INC  = 2'd1,
		SP_DEC  = 2'd2
	} sp_op_e;

	typedef enum logic [5:0] {
		OP_ADR0 = 6'd0, // Address add, low byte
		OP_ADR1 = 6'd1, // Address add with carry, high byte
		OP_ADC  = 6'd2,
		OP_AND  = 6'd3,
		OP_ASL  = 6'd4,
		OP_BNE  = 6'd7,
		OP_BEQ  = 6'd15,
		OP_BRA  = 6'd22,
		OP_CLC  = 6'd23,
		OP_DEC  = 6'd28,
		OP_INC  = 6'd30,
		OP_PASS = 6'd32,
		OP_SEC  = 6'd46
	} alu_op_e;

	// One opcode byte read as addressing group or as branch condition
	typedef union packed {
		struct packed {
			logic [2:0] aaa;
			logic [2:0] bbb; // Addressing mode
			logic [1:0] cc;
		} group_view;
		struct packed {
			logic [1:0] flag_sel; // 11 selects Z flag
			logic       flag_val;
			logic [4:0] branch_tag;
		} branch_view;
	} opcode_u;

	typedef enum logic [3:0] {
		IC_IMPLIED, IC_IMMEDIATE, IC_ZP, IC_ABS, IC_BRANCH,
		IC_PUSH, IC_PULL, IC_JMP, IC_NONE
	} inst_class_e;

	typedef enum logic [2:0] {
		NONE_REG, A_REG, X_REG, Y_REG, SP_REG
	} reg_target_e;

	typedef struct packed {
		inst_class_e inst_class;
		logic        is_store;
		logic        is_rmw;
		reg_target_e target;
		alu_sel_e    alu_sel_ex; // Operand in the execute cycle
		alu_sel_e    alu_sel_ad; // Index added in the address cycle
		alu_op_e     alu_op_ex;
	} decoded_t;

	typedef struct packed {
		logic       instruction_load;
		logic       increment_pc;
		sp_op_e     sp_op;
		logic       a_load;
		logic       x_load;
		logic       y_load;
		logic       sp_load;
		logic       dirl_load;
		logic       dirh_load;
		logic       branch_load;
		logic       pcl_load;
		logic       pch_load;
		logic       jmp_load;
		logic       rst_load;
		logic       read_write; // High for a memory write
		write_sel_e write_select;
		addr_sel_e  address_select;
		alu_sel_e   alu_select;
		alu_op_e    alu_opcode;
		state_e     state; // Debug view of the FSM
	} ctrl_word_t;

endpackage

`default_nettype wire

// File: hw/cycle_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module cycle_sequencer (
	input  wire logic                clk,
	input  wire logic                rst,
	input  wire cu_pkg::inst_class_e fetch_class,
	input  wire cu_pkg::decoded_t    dec,
	input  wire logic                branch_valid,
	output cu_pkg::state_e           state
);

	cu_pkg::state_e next_state;

	always_comb begin
		next_state = cu_pkg::ST_FETCH;
		case (state)
			cu_pkg::ST_FETCH: begin
				case (fetch_class)
					cu_pkg::IC_IMPLIED,
					cu_pkg::IC_IMMEDIATE: next_state = cu_pkg::ST_IM0;
					cu_pkg::IC_ZP:        next_state = cu_pkg::ST_ZP0;
					cu_pkg::IC_ABS,
					cu_pkg::IC_JMP:       next_state = cu_pkg::ST_ABS0;
					cu_pkg::IC_BRANCH:    next_state = cu_pkg::ST_BRANCH_CHECK;
					cu_pkg::IC_PUSH:      next_state = cu_pkg::ST_PUSH;
					cu_pkg::IC_PULL:      next_state = cu_pkg::ST_PULL;
					default:              next_state = cu_pkg::ST_FETCH; // Unknown opcode
				endcase
			end
			cu_pkg::ST_ZP0: begin
				if (dec.is_store)
					next_state = cu_pkg::ST_ZP_STORE;
				else
					next_state = cu_pkg::ST_ZP1;
			end
			cu_pkg::ST_ZP1: begin
				if (dec.is_rmw)
					next_state = cu_pkg::ST_ZP_WRITE;
			end
			cu_pkg::ST_ABS0: begin
				if (dec.inst_class == cu_pkg::IC_JMP)
					next_state = cu_pkg::ST_ABS_JMP;
				else
					next_state = cu_pkg::ST_ABS1;
			end
			cu_pkg::ST_ABS1: begin
				if (dec.is_store)
					next_state = cu_pkg::ST_ABS_STORE;
				else
					next_state = cu_pkg::ST_ABS2;
			end
			cu_pkg::ST_ABS2: begin
				if (dec.is_rmw)
					next_state = cu_pkg::ST_ABS_WRITE;
			end
			cu_pkg::ST_BRANCH_CHECK: begin
				if (branch_valid)
					next_state = cu_pkg::ST_BRANCH_GO; // Taken branch adds a cycle
			end
			cu_pkg::ST_RST0: next_state = cu_pkg::ST_RST1;
			cu_pkg::ST_RST1: next_state = cu_pkg::ST_RST2;
			default:         next_state = cu_pkg::ST_FETCH;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst) begin
			state <= cu_pkg::ST_RST0;
		end else begin
			state <= next_state;
		end
	end

	a_state_kept: assert property (@(posedge clk) disable iff (!rst)
		state inside {cu_pkg::ST_FETCH, cu_pkg::ST_IM0, cu_pkg::ST_ZP0, cu_pkg::ST_ZP1,
			cu_pkg::ST_ABS0, cu_pkg::ST_ABS1, cu_pkg::ST_ABS2, cu_pkg::ST_ZP_WRITE,
			cu_pkg::ST_ABS_WRITE, cu_pkg::ST_ZP_STORE, cu_pkg::ST_ABS_STORE,
			cu_pkg::ST_BRANCH_CHECK, cu_pkg::ST_BRANCH_GO, cu_pkg::ST_PUSH,
			cu_pkg::ST_PULL, cu_pkg::ST_ABS_JMP, cu_pkg::ST_RST0, cu_pkg::ST_RST1,
			cu_pkg::ST_RST2})
		else $error("cycle_sequencer: illegal state %0d", state);

endmodule

`default_nettype wire

// File: hw/opcode_decode.sv
`timescale 1ns/1ps
`default_nettype none

module opcode_decode (
	input  wire logic                clk,
	input  wire logic                rst,
	input  wire logic [7:0]          opcode,
	input  wire cu_pkg::state_e      state,
	output cu_pkg::inst_class_e      fetch_class,
	output cu_pkg::decoded_t         dec
);

	localparam logic [7:0] OPC_RESET = 8'h02; // Unused opcode that decodes to NONE

	cu_pkg::opcode_u opcode_reg;

	function automatic cu_pkg::inst_class_e classify(input cu_pkg::opcode_u op);
		cu_pkg::inst_class_e cls;
		case (op)
			8'hA9, 8'hA5, 8'hAD, 8'hA2, 8'hA0, 8'h85, 8'h8D, 8'h86,
			8'h69, 8'h29, 8'hE6, 8'h0E: begin
				case (op.group_view.bbb)
					3'b000, 3'b010: cls = cu_pkg::IC_IMMEDIATE;
					3'b001:         cls = cu_pkg::IC_ZP;
					default:        cls = cu_pkg::IC_ABS;
				endcase
			end
			8'hE8, 8'h88, 8'hAA, 8'h9A, 8'h18, 8'h38, 8'hEA: cls = cu_pkg::IC_IMPLIED;
			8'hF0, 8'hD0, 8'h80: cls = cu_pkg::IC_BRANCH;
			8'h48:   cls = cu_pkg::IC_PUSH;
			8'h68:   cls = cu_pkg::IC_PULL;
			8'h4C:   cls = cu_pkg::IC_JMP;
			default: cls = cu_pkg::IC_NONE;
		endcase
		return cls;
	endfunction

	function automatic cu_pkg::decoded_t decode(input cu_pkg::opcode_u op);
		cu_pkg::decoded_t d;
		d.inst_class = classify(op);
		d.is_store   = op inside {8'h85, 8'h8D, 8'h86};
		d.is_rmw     = op inside {8'hE6, 8'h0E};
		d.alu_sel_ad = cu_pkg::AL_Z; // No indexed modes decoded

		case (op)
			8'hA9, 8'hA5, 8'hAD, 8'h69, 8'h29, 8'h68: d.target = cu_pkg::A_REG;
			8'hA2, 8'hE8, 8'hAA: d.target = cu_pkg::X_REG;
			8'hA0, 8'h88:        d.target = cu_pkg::Y_REG;
			8'h9A:               d.target = cu_pkg::SP_REG; // TXS
			default:             d.target = cu_pkg::NONE_REG;
		endcase

		case (op)
			8'h69, 8'h29, 8'h85, 8'h8D, 8'h48, 8'hAA: d.alu_sel_ex = cu_pkg::AL_A;
			8'h86, 8'hE8, 8'h9A: d.alu_sel_ex = cu_pkg::AL_X;
			8'h88:               d.alu_sel_ex = cu_pkg::AL_Y;
			8'h18, 8'h38, 8'hF0, 8'hD0, 8'h80: d.alu_sel_ex = cu_pkg::AL_F;
			default:             d.alu_sel_ex = cu_pkg::AL_M; // Loads, RMW, PLA
		endcase

		case (op)
			8'h69:        d.alu_op_ex = cu_pkg::OP_ADC;
			8'h29:        d.alu_op_ex = cu_pkg::OP_AND;
			8'h0E:        d.alu_op_ex = cu_pkg::OP_ASL;
			8'hE6, 8'hE8: d.alu_op_ex = cu_pkg::OP_INC;
			8'h88:        d.alu_op_ex = cu_pkg::OP_DEC;
			8'h18:        d.alu_op_ex = cu_pkg::OP_CLC;
			8'h38:        d.alu_op_ex = cu_pkg::OP_SEC;
			8'h80:        d.alu_op_ex = cu_pkg::OP_BRA;
			8'hF0, 8'hD0: begin
				// Conditional branch on Z with polarity from bit 5
				d.alu_op_ex = op.branch_view.flag_val ? cu_pkg::OP_BEQ : cu_pkg::OP_BNE;
			end
			default:      d.alu_op_ex = cu_pkg::OP_PASS;
		endcase
		return d;
	endfunction

	always_ff @(posedge clk) begin
		if (!rst) begin
			opcode_reg <= OPC_RESET;
		end else if (state == cu_pkg::ST_FETCH) begin
			opcode_reg <= opcode; // Captured with instruction_load
		end
	end

	assign fetch_class = classify(opcode); // Live byte picks the next state
	assign dec         = decode(opcode_reg);

	a_store_rmw_excl: assert property (@(posedge clk) disable iff (!rst)
		!(dec.is_store && dec.is_rmw))
		else $error("opcode_decode: store and RMW decoded together");

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build and run the control unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f flist.f --top-module tb_control_unit

# A failing run still leaves its log for the search below
./obj_dir/Vtb_control_unit > sim.log 2>&1 || true
cat sim.log

if grep -q "Something failed" sim.log; then
	exit 1
fi
if ! grep -q "Everything OK" sim.log; then
	echo "Simulation ended without a result"
	exit 1
fi
exit 0

// File: include/tb_opcode_table.svh
`ifndef TB_OPCODE_TABLE_SVH
`define TB_OPCODE_TABLE_SVH
`default_nettype none

// Cycles count FETCH; branches add one when taken
typedef struct packed {
	logic [7:0]          opcode;
	cu_pkg::inst_class_e cls;
	logic [3:0]          cycles;
	cu_pkg::reg_target_e target;
} tb_op_t;

localparam int TB_OP_COUNT = 25;

localparam tb_op_t TB_OP_TABLE [TB_OP_COUNT] = '{
	'{8'hA9, cu_pkg::IC_IMMEDIATE, 4'd2, cu_pkg::A_REG},  // LDA #
	'{8'hA5, cu_pkg::IC_ZP,        4'd3, cu_pkg::A_REG},  // LDA zp
	'{8'hAD, cu_pkg::IC_ABS,       4'd4, cu_pkg::A_REG},  // LDA abs
	'{8'hA2, cu_pkg::IC_IMMEDIATE, 4'd2, cu_pkg::X_REG},
	'{8'hA0, cu_pkg::IC_IMMEDIATE, 4'd2, cu_pkg::Y_REG},
	'{8'h85, cu_pkg::IC_ZP,        4'd3, cu_pkg::NONE_REG}, // STA zp
	'{8'h8D, cu_pkg::IC_ABS,       4'd4, cu_pkg::NONE_REG},
	'{8'h86, cu_pkg::IC_ZP,        4'd3, cu_pkg::NONE_REG},
	'{8'h69, cu_pkg::IC_IMMEDIATE, 4'd2, cu_pkg::A_REG},
	'{8'h29, cu_pkg::IC_IMMEDIATE, 4'd2, cu_pkg::A_REG},
	'{8'hE6, cu_pkg::IC_ZP,        4'd4, cu_pkg::NONE_REG}, // INC zp, RMW
	'{8'h0E, cu_pkg::IC_ABS,       4'd5, cu_pkg::NONE_REG}, // ASL abs, RMW
	'{8'hE8, cu_pkg::IC_IMPLIED,   4'd2, cu_pkg::X_REG},
	'{8'h88, cu_pkg::IC_IMPLIED,   4'd2, cu_pkg::Y_REG},
	'{8'hAA, cu_pkg::IC_IMPLIED,   4'd2, cu_pkg::X_REG},
	'{8'h9A, cu_pkg::IC_IMPLIED,   4'd2, cu_pkg::SP_REG},
	'{8'h18, cu_pkg::IC_IMPLIED,   4'd2, cu_pkg::NONE_REG},
	'{8'h38, cu_pkg::IC_IMPLIED,   4'd2, cu_pkg::NONE_REG},
	'{8'hEA, cu_pkg::IC_IMPLIED,   4'd2, cu_pkg::NONE_REG},
	'{8'hF0, cu_pkg::IC_BRANCH,    4'd2, cu_pkg::NONE_REG},
	'{8'hD0, cu_pkg::IC_BRANCH,    4'd2, cu_pkg::NONE_REG},
	'{8'h80, cu_pkg::IC_BRANCH,    4'd2, cu_pkg::NONE_REG},
	'{8'h48, cu_pkg::IC_PUSH,      4'd2, cu_pkg::NONE_REG},
	'{8'h68, cu_pkg::IC_PULL,      4'd2, cu_pkg::A_REG},
	'{8'h4C, cu_pkg::IC_JMP,       4'd3, cu_pkg::NONE_REG}
};

`default_nettype wire
`endif

// File: tests/tb_control_unit.sv
`timescale 1ns/1ps
`include "tb_opcode_table.svh"
`default_nettype none

module tb_control_unit;

	localparam int CLK_PERIOD  = 40;
	localparam int DRIVE_DELAY = 5; // Inputs change after the rising edge
	localparam int NUM_INSTR   = 400;
	localparam int WATCHDOG_NS = NUM_INSTR * 5 * CLK_PERIOD + 20 * CLK_PERIOD;
	localparam logic [7:0] IDLE_OP = 8'h00; // Unused opcode driven outside FETCH

	logic               clk;
	logic               rst;
	logic [7:0]         opcode;
	logic               branch_valid;
	cu_pkg::ctrl_word_t ctrl;

	tb_op_t cur; // Instruction in flight
	int     cyc; // Cycle within it with FETCH as 1
	int     len;
	logic   taken;
	int     rst_step; // 1 to 3 through the reset vector sequence
	logic   checking;
	int     errors;
	int     idx;

	logic               running, last, is_mem, is_rmw, is_store;
	logic               exp_il, exp_rw, exp_ws_chk, exp_addr_chk;
	logic [2:0]         exp_rst;
	logic [3:0]         exp_loads;
	logic [1:0]         exp_jumps;
	cu_pkg::write_sel_e exp_ws;
	cu_pkg::addr_sel_e  exp_addr;
	cu_pkg::sp_op_e     exp_sp;

	control_unit dut (
		.clk          (clk),
		.rst          (rst),
		.opcode       (opcode),
		.branch_valid (branch_valid),
		.ctrl         (ctrl)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	task automatic report_mismatch(input string name, input int expected, input int actual);
		errors = errors + 1;
		$display("[FAIL] %0d ns %s expected 0x%0h got 0x%0h", $time, name, expected, actual);
	endtask

	function automatic logic draw_bit();
		return ($urandom() & 32'd1) != 32'd0;
	endfunction

	// Expected control word for the cycle the tracker stands in
	always_comb begin
		running   = checking && (rst_step == 0);
		len       = int'(cur.cycles) + int'(taken);
		last      = running && (cyc == len);
		is_mem    = cur.cls inside {cu_pkg::IC_ZP, cu_pkg::IC_ABS};
		is_rmw    = (cur.cls == cu_pkg::IC_ZP && cur.cycles == 4'd4) ||
			(cur.cls == cu_pkg::IC_ABS && cur.cycles == 4'd5);
		is_store  = is_mem && !is_rmw && (cur.target == cu_pkg::NONE_REG);
		exp_il    = running && (cyc == 1);
		exp_rst   = {rst_step == 1, rst_step == 2, rst_step == 3};
		exp_rw    = last && (is_store || is_rmw || cur.cls == cu_pkg::IC_PUSH);
		exp_loads = {last && cur.target == cu_pkg::A_REG, last && cur.target == cu_pkg::X_REG,
			last && cur.target == cu_pkg::Y_REG, last && cur.target == cu_pkg::SP_REG};
		exp_jumps = {running && cur.cls == cu_pkg::IC_BRANCH && taken && cyc == 3,
			running && cur.cls == cu_pkg::IC_JMP && cyc == 3};

		exp_ws_chk = !exp_rw || is_store || is_rmw; // Push data source left open
		exp_ws     = cu_pkg::WS_ZERO;
		if (exp_rw && is_store)
			exp_ws = cu_pkg::WS_ALU;
		else if (exp_rw && is_rmw)
			exp_ws = cu_pkg::WS_RESULT;

		exp_addr_chk = rst_step inside {2, 3} ||
			(exp_rw && (is_store || cur.cls == cu_pkg::IC_PUSH));
		if (rst_step == 2)
			exp_addr = cu_pkg::AS_RVL;
		else if (rst_step == 3)
			exp_addr = cu_pkg::AS_RVH;
		else if (cur.cls == cu_pkg::IC_PUSH)
			exp_addr = cu_pkg::AS_STACK;
		else if (cur.cls == cu_pkg::IC_ZP)
			exp_addr = cu_pkg::AS_ZERO;
		else
			exp_addr = cu_pkg::AS_ABS;

		exp_sp = cu_pkg::SP_HOLD;
		if (running && cyc == 2 && cur.cls == cu_pkg::IC_PUSH)
			exp_sp = cu_pkg::SP_DEC;
		else if (running && cyc == 2 && cur.cls == cu_pkg::IC_PULL)
			exp_sp = cu_pkg::SP_INC;
	end

	a_fetch: assert property (@(posedge clk) checking |-> ctrl.instruction_load == exp_il)
		else report_mismatch("instruction_load", int'($sampled(exp_il)),
			int'($sampled(ctrl.instruction_load)));
	a_reset_seq: assert property (@(posedge clk)
		checking |-> {ctrl.rst_load, ctrl.pcl_load, ctrl.pch_load} == exp_rst)
		else report_mismatch("{rst_load,pcl_load,pch_load}", int'($sampled(exp_rst)),
			int'($sampled({ctrl.rst_load, ctrl.pcl_load, ctrl.pch_load})));
	a_write: assert property (@(posedge clk) checking |-> ctrl.read_write == exp_rw)
		else report_mismatch("read_write", int'($sampled(exp_rw)),
			int'($sampled(ctrl.read_write)));
	a_write_sel: assert property (@(posedge clk)
		(checking && exp_ws_chk) |-> ctrl.write_select == exp_ws)
		else report_mismatch("write_select", int'($sampled(exp_ws)),
			int'($sampled(ctrl.write_select)));
	a_addr_sel: assert property (@(posedge clk)
		(checking && exp_addr_chk) |-> ctrl.address_select == exp_addr)
		else report_mismatch("address_select", int'($sampled(exp_addr)),
			int'($sampled(ctrl.address_select)));
	a_reg_loads: assert property (@(posedge clk)
		checking |-> {ctrl.a_load, ctrl.x_load, ctrl.y_load, ctrl.sp_load} == exp_loads)
		else report_mismatch("{a_load,x_load,y_load,sp_load}", int'($sampled(exp_loads)),
			int'($sampled({ctrl.a_load, ctrl.x_load, ctrl.y_load, ctrl.sp_load})));
	a_stack_op: assert property (@(posedge clk) checking |-> ctrl.sp_op == exp_sp)
		else report_mismatch("sp_op", int'($sampled(exp_sp)), int'($sampled(ctrl.sp_op)));
	a_pc_jumps: assert property (@(posedge clk)
		checking |-> {ctrl.branch_load, ctrl.jmp_load} == exp_jumps)
		else report_mismatch("{branch_load,jmp_load}", int'($sampled(exp_jumps)),
			int'($sampled({ctrl.branch_load, ctrl.jmp_load})));

	initial begin
		void'($urandom(32'h9196_d6a4));
		rst          = 1'b0;
		opcode       = IDLE_OP;
		branch_valid = 1'b0;
		cur          = '{IDLE_OP, cu_pkg::IC_NONE, 4'd1, cu_pkg::NONE_REG};
		cyc          = 0;
		taken        = 1'b0;
		rst_step     = 0;
		checking     = 1'b0;
		errors       = 0;
		idx          = 0;
		repeat (3) @(posedge clk);
		#(DRIVE_DELAY);
		rst      = 1'b1;
		checking = 1'b1;
		rst_step = 1;
		repeat (2) begin
			@(posedge clk);
			#(DRIVE_DELAY);
			rst_step = rst_step + 1;
		end
		for (int n = 0; n < NUM_INSTR; n++) begin
			@(posedge clk);
			#(DRIVE_DELAY);
			rst_step     = 0;
			idx          = int'($urandom_range(TB_OP_COUNT - 1, 0));
			cur          = TB_OP_TABLE[idx];
			cyc          = 1;
			taken        = 1'b0;
			opcode       = ctrl.instruction_load ? cur.opcode : IDLE_OP;
			branch_valid = draw_bit();
			while (cyc < int'(cur.cycles) + int'(taken)) begin
				@(posedge clk);
				#(DRIVE_DELAY);
				cyc          = cyc + 1;
				opcode       = IDLE_OP;
				branch_valid = draw_bit();
				if (cyc == 2 && cur.cls == cu_pkg::IC_BRANCH)
					taken = branch_valid; // Level seen in BRANCH_CHECK
			end
		end
		@(posedge clk); // Last cycle gets checked on this edge
		#(DRIVE_DELAY);
		checking = 1'b0;
		$display("Run complete: %0d instructions, %0d errors", NUM_INSTR, errors);
		if (errors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Timeout: run did not finish within %0d ns, %0d errors so far",
			WATCHDOG_NS, errors);
		$display("Something failed");
		$finish;
	end

endmodule

`default_nettype wire
